// ==== compile.f ====
+incdir+.
dma_fe_pkg.sv
dma_fe_conf_regs.sv
dma_fe_rr_arb.sv
dma_fe_tf_tracker.sv
dma_cluster_frontend.sv
tb_dma_cluster_frontend.sv

// ==== dma_cluster_frontend.sv ====
// cluster dma command frontend
`timescale 1ns/1ps
`include "dma_fe_settings.svh"

module dma_cluster_frontend (
    input  logic                                         clk_i,
    input  logic                                         rst_ni,
    input  dma_fe_pkg::ctrl_req_t [`DMA_FE_NUM_REGS-1:0] ctrl_req_i,
    output dma_fe_pkg::ctrl_rsp_t [`DMA_FE_NUM_REGS-1:0] ctrl_rsp_o,
    output logic                                         burst_valid_o,
    input  logic                                         burst_ready_i,
    output dma_fe_pkg::burst_req_t                       burst_req_o,
    input  logic                                         trans_complete_i,
    input  logic                                         be_idle_i,
    output logic                                         busy_o,
    output logic [`DMA_FE_NUM_CORES-1:0]                 term_event_o,
    output logic [`DMA_FE_NUM_CORES-1:0]                 term_irq_o,
    output logic                                         term_event_pe_o,
    output logic                                         term_irq_pe_o,
    output logic [`DMA_FE_NUM_CORES-1:0]                 no_req_pending_o
);
    import dma_fe_pkg::*;

    logic          [`DMA_FE_NUM_REGS-1:0] desc_valid;
    logic          [`DMA_FE_NUM_REGS-1:0] desc_ready;
    transf_descr_t [`DMA_FE_NUM_REGS-1:0] desc;
    tf_id_t                               next_id;
    tf_id_t                               done_id;
    src_idx_t                             arb_idx;
    logic                                 issue;

    assign busy_o = ~be_idle_i;
    assign issue  = burst_valid_o & burst_ready_i;

    // cores first and the peripheral set at the top index
    for (genvar i = 0; i < `DMA_FE_NUM_REGS; i++) begin : gen_regs
        dma_fe_conf_regs dma_fe_conf_regs_i (
            .clk_i        ( clk_i         ),
            .rst_ni       ( rst_ni        ),
            .ctrl_req_i   ( ctrl_req_i[i] ),
            .ctrl_rsp_o   ( ctrl_rsp_o[i] ),
            .next_id_i    ( next_id       ),
            .done_id_i    ( done_id       ),
            .busy_i       ( busy_o        ),
            .desc_valid_o ( desc_valid[i] ),
            .desc_ready_i ( desc_ready[i] ),
            .desc_o       ( desc[i]       )
        );
    end

    dma_fe_rr_arb dma_fe_rr_arb_i (
        .clk_i         ( clk_i         ),
        .rst_ni        ( rst_ni        ),
        .valid_i       ( desc_valid    ),
        .desc_i        ( desc          ),
        .ready_o       ( desc_ready    ),
        .burst_valid_o ( burst_valid_o ),
        .burst_ready_i ( burst_ready_i ),
        .burst_req_o   ( burst_req_o   ),
        .idx_o         ( arb_idx       )
    );

    dma_fe_tf_tracker dma_fe_tf_tracker_i (
        .clk_i            ( clk_i            ),
        .rst_ni           ( rst_ni           ),
        .issue_i          ( issue            ),
        .issue_idx_i      ( arb_idx          ),
        .trans_complete_i ( trans_complete_i ),
        .next_id_o        ( next_id          ),
        .done_id_o        ( done_id          ),
        .no_req_pending_o ( no_req_pending_o ),
        .term_event_o     ( term_event_o     ),
        .term_irq_o       ( term_irq_o       ),
        .term_event_pe_o  ( term_event_pe_o  ),
        .term_irq_pe_o    ( term_irq_pe_o    )
    );

endmodule

// ==== dma_fe_conf_regs.sv ====
// dma descriptor register set
`timescale 1ns/1ps
`include "dma_fe_settings.svh"

module dma_fe_conf_regs (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  dma_fe_pkg::ctrl_req_t     ctrl_req_i,
    output dma_fe_pkg::ctrl_rsp_t     ctrl_rsp_o,
    input  dma_fe_pkg::tf_id_t        next_id_i,
    input  dma_fe_pkg::tf_id_t        done_id_i,
    input  logic                      busy_i,
    output logic                      desc_valid_o,
    input  logic                      desc_ready_i,
    output dma_fe_pkg::transf_descr_t desc_o
);
    import dma_fe_pkg::*;

    transf_descr_t desc_q;
    logic [7:0]    offset;
    logic          launch;
    logic          gnt;
    logic          r_valid_q;
    logic [31:0]   r_data_d;
    logic [31:0]   r_data_q;

    // merge write data into a register under byte enables
    function automatic logic [31:0] apply_be(input logic [31:0] old_val,
                                             input logic [31:0] new_val,
                                             input logic [3:0]  be);
        logic [31:0] res;
        res = old_val;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = new_val[8*b +: 8];
            end
        end
        return res;
    endfunction

    assign offset = ctrl_req_i.addr[7:0];
    assign launch = ctrl_req_i.req & ~ctrl_req_i.we & (offset == `DMA_FE_REG_LAUNCH);

    // only nonzero launches wait for the arbiter
    assign desc_valid_o = launch & (desc_q.num_bytes != '0);
    assign gnt          = desc_valid_o ? desc_ready_i : ctrl_req_i.req;

    // read mux where writes answer with zero
    always_comb begin
        r_data_d = '0;
        if (!ctrl_req_i.we) begin
            case (offset)
                `DMA_FE_REG_SRC:    r_data_d = desc_q.src_addr;
                `DMA_FE_REG_DST:    r_data_d = desc_q.dst_addr;
                `DMA_FE_REG_LEN:    r_data_d = desc_q.num_bytes;
                `DMA_FE_REG_CONF:   r_data_d = {29'b0, desc_q.serialize,
                                                desc_q.deburst, desc_q.decouple};
                `DMA_FE_REG_STATUS: r_data_d = {31'b0, busy_i};
                `DMA_FE_REG_LAUNCH: r_data_d = next_id_i;
                `DMA_FE_REG_DONE:   r_data_d = done_id_i;
                default:            r_data_d = '0;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            desc_q <= '0;
        end else if (ctrl_req_i.req && ctrl_req_i.we) begin
            case (offset)
                `DMA_FE_REG_SRC: desc_q.src_addr <=
                    apply_be(desc_q.src_addr, ctrl_req_i.wdata, ctrl_req_i.be);
                `DMA_FE_REG_DST: desc_q.dst_addr <=
                    apply_be(desc_q.dst_addr, ctrl_req_i.wdata, ctrl_req_i.be);
                `DMA_FE_REG_LEN: desc_q.num_bytes <=
                    apply_be(desc_q.num_bytes, ctrl_req_i.wdata, ctrl_req_i.be);
                `DMA_FE_REG_CONF: begin
                    if (ctrl_req_i.be[0]) begin
                        desc_q.decouple  <= ctrl_req_i.wdata[0];
                        desc_q.deburst   <= ctrl_req_i.wdata[1];
                        desc_q.serialize <= ctrl_req_i.wdata[2];
                    end
                end
                default: ;
            endcase
        end
    end

    // response follows the grant by one cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            r_valid_q <= 1'b0;
        end else begin
            r_valid_q <= gnt;
        end
    end

    always_ff @(posedge clk_i) begin
        if (gnt) begin
            r_data_q <= r_data_d;
        end
    end

    assign ctrl_rsp_o.gnt     = gnt;
    assign ctrl_rsp_o.r_valid = r_valid_q;
    assign ctrl_rsp_o.r_data  = r_data_q;
    assign desc_o             = desc_q;

endmodule

// ==== dma_fe_pkg.sv ====
// dma frontend types
`include "dma_fe_settings.svh"

package dma_fe_pkg;

    // register set index with the peripheral set last
    typedef logic [`DMA_FE_IDX_WIDTH-1:0] src_idx_t;

    // transfer ids wrap at 32 bits
    typedef logic [31:0] tf_id_t;

    // descriptor as programmed by a master
    typedef struct packed {
        logic [`DMA_FE_ADDR_WIDTH-1:0] src_addr;
        logic [`DMA_FE_ADDR_WIDTH-1:0] dst_addr;
        logic [`DMA_FE_ADDR_WIDTH-1:0] num_bytes;
        logic                          decouple;
        logic                          deburst;
        logic                          serialize;
    } transf_descr_t;

    // register bus request
    typedef struct packed {
        logic        req;
        logic        we;
        logic [3:0]  be;
        logic [31:0] addr;
        logic [31:0] wdata;
    } ctrl_req_t;

    // register bus response
    typedef struct packed {
        logic        gnt;
        logic        r_valid;
        logic [31:0] r_data;
    } ctrl_rsp_t;

    // incrementing 1D burst for the backend
    typedef struct packed {
        logic [`DMA_FE_ADDR_WIDTH-1:0] src;
        logic [`DMA_FE_ADDR_WIDTH-1:0] dst;
        logic [`DMA_FE_ADDR_WIDTH-1:0] num_bytes;
        logic                          decouple_rw;
        logic                          deburst;
        logic                          serialize;
    } burst_req_t;

endpackage

// ==== dma_fe_rr_arb.sv ====
// round-robin descriptor arbiter
`timescale 1ns/1ps
`include "dma_fe_settings.svh"

module dma_fe_rr_arb (
    input  logic                                             clk_i,
    input  logic                                             rst_ni,
    input  logic [`DMA_FE_NUM_REGS-1:0]                      valid_i,
    input  dma_fe_pkg::transf_descr_t [`DMA_FE_NUM_REGS-1:0] desc_i,
    output logic [`DMA_FE_NUM_REGS-1:0]                      ready_o,
    output logic                                             burst_valid_o,
    input  logic                                             burst_ready_i,
    output dma_fe_pkg::burst_req_t                           burst_req_o,
    output dma_fe_pkg::src_idx_t                             idx_o
);
    import dma_fe_pkg::*;

    src_idx_t      prio_q;
    logic          lock_q;
    src_idx_t      lock_idx_q;
    src_idx_t      rr_idx;
    src_idx_t      sel_idx;
    transf_descr_t sel_desc;

    // first valid set at or after the priority pointer
    always_comb begin
        int  cand;
        logic found;
        found  = 1'b0;
        rr_idx = prio_q;
        for (int k = 0; k < `DMA_FE_NUM_REGS; k++) begin
            cand = int'(prio_q) + k;
            if (cand >= `DMA_FE_NUM_REGS) begin
                cand = cand - `DMA_FE_NUM_REGS;
            end
            if (!found && valid_i[cand]) begin
                found  = 1'b1;
                rr_idx = src_idx_t'(cand);
            end
        end
    end

    // an offered choice stays until the backend takes it
    assign sel_idx       = lock_q ? lock_idx_q : rr_idx;
    assign sel_desc      = desc_i[sel_idx];
    assign burst_valid_o = valid_i[sel_idx];
    assign idx_o         = sel_idx;

    always_comb begin
        ready_o          = '0;
        ready_o[sel_idx] = burst_valid_o & burst_ready_i;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            prio_q     <= '0;
            lock_q     <= 1'b0;
            lock_idx_q <= '0;
        end else begin
            lock_q     <= burst_valid_o & ~burst_ready_i;
            lock_idx_q <= sel_idx;
            if (burst_valid_o && burst_ready_i) begin
                prio_q <= (sel_idx == src_idx_t'(`DMA_FE_NUM_REGS - 1)) ? '0 : sel_idx + 1'b1;
            end
        end
    end

    assign burst_req_o.src         = sel_desc.src_addr;
    assign burst_req_o.dst         = sel_desc.dst_addr;
    assign burst_req_o.num_bytes   = sel_desc.num_bytes;
    assign burst_req_o.decouple_rw = sel_desc.decouple;
    assign burst_req_o.deburst     = sel_desc.deburst;
    assign burst_req_o.serialize   = sel_desc.serialize;

endmodule

// ==== dma_fe_settings.svh ====
// dma frontend settings
`ifndef DMA_FE_SETTINGS_SVH
`define DMA_FE_SETTINGS_SVH

// cluster size
`define DMA_FE_NUM_CORES 4
// one register set per core plus one for the peripheral master
`define DMA_FE_NUM_REGS (`DMA_FE_NUM_CORES + 1)

`define DMA_FE_ADDR_WIDTH 32
`define DMA_FE_IDX_WIDTH 3

// outstanding transfers and per-core pending count
`define DMA_FE_TF_FIFO_DEPTH 8
`define DMA_FE_CNT_WIDTH 4

// offsets within one register set
`define DMA_FE_REG_SRC    8'h00
`define DMA_FE_REG_DST    8'h04
`define DMA_FE_REG_LEN    8'h08
`define DMA_FE_REG_CONF   8'h0C
`define DMA_FE_REG_STATUS 8'h10
`define DMA_FE_REG_LAUNCH 8'h14
`define DMA_FE_REG_DONE   8'h18
`endif

// ==== dma_fe_testdata.txt ====
# columns: W set offset be data | R set offset expected | L set expected_id
# P set_a set_b id_a id_b | S stall_cycles | C completions; all fields hex
W 1 08 f 00000040
W 3 04 f 00003000
W 3 08 f 00000080
P 1 3 00000000 00000001
W 0 00 f 12345678
W 0 00 2 0000ab00
R 0 00 1234ab78
W 0 04 c aabb0000
R 0 04 aabb0000
W 0 08 1 00000120
R 0 08 00000020
W 0 0c 1 0000000d
R 0 0c 00000005
L 0 00000002
R 0 10 00000001
L 2 00000003
W 4 08 f 00000010
L 4 00000003
S 8
L 1 00000004
C 5
R 0 18 00000005
R 2 10 00000000
W 2 08 f 00000010
P 2 0 00000005 00000006
C 2
R 4 18 00000007

// ==== dma_fe_tf_tracker.sv ====
// dma transfer tracker
`timescale 1ns/1ps
`include "dma_fe_settings.svh"

module dma_fe_tf_tracker (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  logic                         issue_i,
    input  dma_fe_pkg::src_idx_t         issue_idx_i,
    input  logic                         trans_complete_i,
    output dma_fe_pkg::tf_id_t           next_id_o,
    output dma_fe_pkg::tf_id_t           done_id_o,
    output logic [`DMA_FE_NUM_CORES-1:0] no_req_pending_o,
    output logic [`DMA_FE_NUM_CORES-1:0] term_event_o,
    output logic [`DMA_FE_NUM_CORES-1:0] term_irq_o,
    output logic                         term_event_pe_o,
    output logic                         term_irq_pe_o
);
    import dma_fe_pkg::*;

    localparam int unsigned PtrWidth = $clog2(`DMA_FE_TF_FIFO_DEPTH);
    localparam int unsigned LastPtr  = `DMA_FE_TF_FIFO_DEPTH - 1;

    tf_id_t              next_id_q;
    tf_id_t              done_id_q;
    src_idx_t            fifo_mem [`DMA_FE_TF_FIFO_DEPTH];
    logic [PtrWidth-1:0] wr_ptr_q;
    logic [PtrWidth-1:0] rd_ptr_q;
    logic [PtrWidth:0]   usage_q;
    logic                fifo_empty;
    logic                fifo_full;
    logic                push;
    logic                pop;
    src_idx_t            fifo_head;

    // issued and retired transfer numbers
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            next_id_q <= '0;
            done_id_q <= '0;
        end else begin
            if (issue_i) begin
                next_id_q <= next_id_q + 1'b1;
            end
            if (trans_complete_i) begin
                done_id_q <= done_id_q + 1'b1;
            end
        end
    end

    assign next_id_o = next_id_q;
    assign done_id_o = done_id_q;

    // source fifo popped in issue order
    assign fifo_empty = (usage_q == '0);
    assign fifo_full  = (usage_q == (PtrWidth + 1)'(`DMA_FE_TF_FIFO_DEPTH));
    assign push       = issue_i & ~fifo_full;
    assign pop        = trans_complete_i & ~fifo_empty;
    assign fifo_head  = fifo_mem[rd_ptr_q];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            usage_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PtrWidth'(LastPtr)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PtrWidth'(LastPtr)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (push && !pop) begin
                usage_q <= usage_q + 1'b1;
            end else if (pop && !push) begin
                usage_q <= usage_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            fifo_mem[wr_ptr_q] <= issue_idx_i;
        end
    end

    // per-core outstanding count without one for the peripheral set
    for (genvar c = 0; c < `DMA_FE_NUM_CORES; c++) begin : gen_pending
        logic [`DMA_FE_CNT_WIDTH-1:0] cnt_q;
        logic                         inc;
        logic                         dec;

        assign inc = issue_i & (issue_idx_i == src_idx_t'(c));
        assign dec = pop & (fifo_head == src_idx_t'(c));

        always_ff @(posedge clk_i or negedge rst_ni) begin
            if (!rst_ni) begin
                cnt_q <= '0;
            end else if (inc && !dec) begin
                cnt_q <= cnt_q + 1'b1;
            end else if (dec && !inc) begin
                cnt_q <= cnt_q - 1'b1;
            end
        end

        assign no_req_pending_o[c] = (cnt_q == '0);
    end

    // every completion notifies all masters
    assign term_event_o    = {`DMA_FE_NUM_CORES{trans_complete_i}};
    assign term_irq_o      = {`DMA_FE_NUM_CORES{trans_complete_i}};
    assign term_event_pe_o = trans_complete_i;
    assign term_irq_pe_o   = trans_complete_i;

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f compile.f \
    --top-module tb_dma_cluster_frontend -o sim_tb

out="$(./obj_dir/sim_tb)"
echo "$out"

if echo "$out" | grep -qx "NO ERRORS"; then
    exit 0
fi
exit 1

// ==== tb_dma_cluster_frontend.sv ====
// dma frontend testbench
`timescale 1ns/1ps
`include "dma_fe_settings.svh"

module tb_dma_cluster_frontend;
    import dma_fe_pkg::*;

    localparam int NumRegs    = `DMA_FE_NUM_REGS;
    localparam int NumCores   = `DMA_FE_NUM_CORES;
    localparam int GntLimit   = 100;
    localparam int CycleLimit = 2000;

    logic                          clk_i;
    logic                          rst_ni = 1'b0;
    ctrl_req_t [NumRegs-1:0]       ctrl_req = '0;
    ctrl_rsp_t [NumRegs-1:0]       ctrl_rsp;
    logic                          burst_valid_o;
    logic                          burst_ready_i = 1'b0;
    burst_req_t                    burst_req_o;
    logic                          trans_complete_i = 1'b0;
    logic                          be_idle_i = 1'b1;
    logic                          busy_o;
    logic [NumCores-1:0]           term_event_o;
    logic [NumCores-1:0]           term_irq_o;
    logic                          term_event_pe_o;
    logic                          term_irq_pe_o;
    logic [NumCores-1:0]           no_req_pending_o;

    // testbench state shared by stimulus and backend model
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          issued = 0;
    int          done_cnt = 0;
    int          stall_left = 0;
    int          cpl_budget = 0;
    int          cpl_wait = 0;
    int          rr_next = 0;
    int          pend_cnt [NumCores];
    logic [31:0] shadow [NumRegs][4];
    burst_req_t  exp_burst [$];
    int          exp_src [$];
    int          outstanding [$];
    bit          hold_q = 1'b0;
    burst_req_t  held_req;

    dma_cluster_frontend dma_cluster_frontend_i (
        .clk_i            ( clk_i            ),
        .rst_ni           ( rst_ni           ),
        .ctrl_req_i       ( ctrl_req         ),
        .ctrl_rsp_o       ( ctrl_rsp         ),
        .burst_valid_o    ( burst_valid_o    ),
        .burst_ready_i    ( burst_ready_i    ),
        .burst_req_o      ( burst_req_o      ),
        .trans_complete_i ( trans_complete_i ),
        .be_idle_i        ( be_idle_i        ),
        .busy_o           ( busy_o           ),
        .term_event_o     ( term_event_o     ),
        .term_irq_o       ( term_irq_o       ),
        .term_event_pe_o  ( term_event_pe_o  ),
        .term_irq_pe_o    ( term_irq_pe_o    ),
        .no_req_pending_o ( no_req_pending_o )
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycles++;
    end

    // run limit
    initial begin
        wait (cycles >= CycleLimit);
        $display("timeout, the run went past %0d cycles", CycleLimit);
        $display("ERRORS FOUND");
        $finish;
    end

    task automatic check_value(input logic [127:0] got, input logic [127:0] exp,
                               input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s, got %0h expected %0h", $time, msg, got, exp);
        end
    endtask

    // descriptor fields as the backend should see them
    function automatic burst_req_t expected_burst(input int s);
        burst_req_t b;
        b.src         = shadow[s][0];
        b.dst         = shadow[s][1];
        b.num_bytes   = shadow[s][2];
        b.decouple_rw = shadow[s][3][0];
        b.deburst     = shadow[s][3][1];
        b.serialize   = shadow[s][3][2];
        return b;
    endfunction

    function automatic ctrl_req_t launch_req();
        ctrl_req_t r;
        r       = '0;
        r.req   = 1'b1;
        r.addr  = {24'b0, `DMA_FE_REG_LAUNCH};
        return r;
    endfunction

    function automatic bit is_nonzero_launch(input int s);
        return ctrl_req[s].req && !ctrl_req[s].we &&
               (ctrl_req[s].addr[7:0] == `DMA_FE_REG_LAUNCH) && (shadow[s][2] != 0);
    endfunction

    // backend model sampling on the edge and driving 1 ns later
    always @(posedge clk_i) begin : backend_model
        int   src;
        logic next_ready;
        logic next_cpl;
        if (rst_ni) begin
            for (int k = 0; k < NumCores; k++) begin
                check_value(no_req_pending_o[k], pend_cnt[k] == 0,
                            $sformatf("no_req_pending of core %0d", k));
            end
            check_value(term_event_o, {NumCores{trans_complete_i}}, "term_event_o");
            check_value(term_event_pe_o, trans_complete_i, "term_event_pe_o");
            check_value(term_irq_o, {NumCores{trans_complete_i}}, "term_irq_o");
            check_value(term_irq_pe_o, trans_complete_i, "term_irq_pe_o");
            check_value(busy_o, !be_idle_i, "busy_o against backend idle");
            for (int s = 0; s < NumRegs; s++) begin
                if (is_nonzero_launch(s) && ctrl_rsp[s].gnt) begin
                    check_value(burst_ready_i, 1'b1, "launch granted while backend stalls");
                end
            end
            if (hold_q) begin
                check_value(burst_valid_o, 1'b1, "burst valid dropped before ready");
                check_value(burst_req_o, held_req, "burst request changed under stall");
            end
            hold_q   = burst_valid_o && !burst_ready_i;
            held_req = burst_req_o;
            if (trans_complete_i) begin
                if (outstanding.size() == 0) begin
                    errors++;
                    $display("completion at %0t with no transfer outstanding", $time);
                end else begin
                    src = outstanding.pop_front();
                    if (src < NumCores) pend_cnt[src]--;
                    done_cnt++;
                end
            end
            if (burst_valid_o && burst_ready_i) begin
                if (exp_burst.size() == 0) begin
                    errors++;
                    $display("burst at %0t that no launch asked for", $time);
                end else begin
                    check_value(burst_req_o, exp_burst.pop_front(), "burst request fields");
                    src = exp_src.pop_front();
                    outstanding.push_back(src);
                    if (src < NumCores) pend_cnt[src]++;
                    issued++;
                end
            end
        end
        if (stall_left > 0) begin
            next_ready = 1'b0;
            stall_left--;
        end else begin
            next_ready = ($urandom % 4) != 0;
        end
        next_cpl = 1'b0;
        if (cpl_budget > 0 && outstanding.size() > 0) begin
            if (cpl_wait == 0) begin
                next_cpl = 1'b1;
                cpl_budget--;
                cpl_wait = $urandom % 4;
            end else begin
                cpl_wait--;
            end
        end
        #1;
        burst_ready_i    = next_ready;
        trans_complete_i = next_cpl;
        be_idle_i        = (outstanding.size() == 0);
    end

    task automatic tick();
        @(posedge clk_i);
        #1;
    endtask

    // one register access returning the read data a cycle after the grant
    task automatic bus_access(input int s, input logic we, input logic [3:0] be,
                              input logic [7:0] offset, input logic [31:0] wdata,
                              output logic [31:0] rdata, output bit ok);
        int n;
        ok    = 1'b0;
        rdata = '0;
        n     = 0;
        ctrl_req[s].req   = 1'b1;
        ctrl_req[s].we    = we;
        ctrl_req[s].be    = be;
        ctrl_req[s].addr  = {24'b0, offset};
        ctrl_req[s].wdata = wdata;
        do begin
            @(posedge clk_i);
            n++;
        end while (!ctrl_rsp[s].gnt && n < GntLimit);
        if (!ctrl_rsp[s].gnt) begin
            errors++;
            $display("set %0d never granted the access at offset %0h", s, offset);
            #1;
            ctrl_req[s] = '0;
        end else begin
            #1;
            ctrl_req[s] = '0;
            @(posedge clk_i);
            check_value(ctrl_rsp[s].r_valid, 1'b1, "read valid after grant");
            rdata = ctrl_rsp[s].r_data;
            ok    = 1'b1;
            #1;
        end
    endtask

    task automatic write_reg(input int s, input logic [7:0] offset, input logic [3:0] be,
                             input logic [31:0] data);
        logic [31:0] rdata;
        bit          ok;
        int          r;
        bus_access(s, 1'b1, be, offset, data, rdata, ok);
        r = offset >> 2;
        if (ok) begin
            check_value(rdata, 32'h0, "response data of a write");
            if (r == 3) begin
                if (be[0]) shadow[s][3] = {29'b0, data[2:0]};
            end else if (r < 3) begin
                for (int b = 0; b < 4; b++) begin
                    if (be[b]) shadow[s][r][8*b +: 8] = data[8*b +: 8];
                end
            end
        end
    endtask

    task automatic read_reg(input int s, input logic [7:0] offset, input logic [31:0] exp);
        logic [31:0] rdata;
        bit          ok;
        bus_access(s, 1'b0, 4'hf, offset, '0, rdata, ok);
        if (ok) check_value(rdata, exp, $sformatf("read of set %0d offset %0h", s, offset));
    endtask

    task automatic queue_burst(input int s);
        if (shadow[s][2] != 0) begin
            exp_burst.push_back(expected_burst(s));
            exp_src.push_back(s);
            rr_next = (s + 1) % NumRegs;
        end
    endtask

    task automatic launch(input int s, input logic [31:0] exp_id);
        logic [31:0] id;
        bit          ok;
        int          id_now;
        id_now = issued;
        queue_burst(s);
        bus_access(s, 1'b0, 4'hf, `DMA_FE_REG_LAUNCH, '0, id, ok);
        if (ok) begin
            check_value(id, exp_id, $sformatf("launch id of set %0d", s));
            check_value(id, id_now, $sformatf("launch id of set %0d against issue count", s));
        end
    endtask

    // two launches in the same cycle with round-robin order
    task automatic launch_pair(input int a, input int b, input logic [31:0] id_a,
                               input logic [31:0] id_b);
        int          first;
        int          second;
        int          won;
        int          n;
        bit          ga;
        bit          gb;
        bit          va;
        bit          vb;
        logic [31:0] da;
        logic [31:0] db;
        first  = (((a - rr_next + NumRegs) % NumRegs) < ((b - rr_next + NumRegs) % NumRegs))
                 ? a : b;
        second = (first == a) ? b : a;
        queue_burst(first);
        queue_burst(second);
        won = -1;
        n   = 0;
        ga  = 1'b0;
        gb  = 1'b0;
        va  = 1'b0;
        vb  = 1'b0;
        ctrl_req[a] = launch_req();
        ctrl_req[b] = launch_req();
        while (!(va && vb) && n < GntLimit) begin
            @(posedge clk_i);
            n++;
            if (ga && !va) begin
                check_value(ctrl_rsp[a].r_valid, 1'b1, "read valid after pair grant");
                da = ctrl_rsp[a].r_data;
                va = 1'b1;
            end
            if (gb && !vb) begin
                check_value(ctrl_rsp[b].r_valid, 1'b1, "read valid after pair grant");
                db = ctrl_rsp[b].r_data;
                vb = 1'b1;
            end
            if (!ga && ctrl_rsp[a].gnt) begin
                ga = 1'b1;
                if (won < 0) won = a;
            end
            if (!gb && ctrl_rsp[b].gnt) begin
                gb = 1'b1;
                if (won < 0) won = b;
            end
            #1;
            if (ga) ctrl_req[a] = '0;
            if (gb) ctrl_req[b] = '0;
        end
        if (!(va && vb)) begin
            errors++;
            $display("launches on sets %0d and %0d were not both served", a, b);
            ctrl_req[a] = '0;
            ctrl_req[b] = '0;
        end else begin
            check_value(won, first, "first winner of the launch pair");
            check_value(da, id_a, $sformatf("launch id of set %0d", a));
            check_value(db, id_b, $sformatf("launch id of set %0d", b));
        end
    endtask

    task automatic stall_backend(input int n);
        stall_left = n;
        tick();
    endtask

    task automatic complete(input int n);
        int target;
        int waited;
        target     = done_cnt + n;
        cpl_budget = cpl_budget + n;
        waited     = 0;
        while (done_cnt < target && waited < 4 * GntLimit) begin
            tick();
            waited++;
        end
        if (done_cnt < target) begin
            errors++;
            $display("only %0d of %0d completions arrived", done_cnt, target);
        end
    endtask

    initial begin
        int          fd;
        string       line;
        logic [7:0]  cmd;
        logic [31:0] f0;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        void'($urandom(93));
        for (int s = 0; s < NumRegs; s++) begin
            for (int r = 0; r < 4; r++) shadow[s][r] = '0;
        end
        for (int k = 0; k < NumCores; k++) pend_cnt[k] = 0;
        repeat (5) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        fd = $fopen("dma_fe_testdata.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open dma_fe_testdata.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() < 2 || line[0] == "#") continue;
                void'($sscanf(line, "%c %h %h %h %h", cmd, f0, f1, f2, f3));
                case (cmd)
                    "W":     write_reg(f0, f1[7:0], f2[3:0], f3);
                    "R":     read_reg(f0, f1[7:0], f2);
                    "L":     launch(f0, f1);
                    "P":     launch_pair(f0, f1, f2, f3);
                    "S":     stall_backend(f0);
                    "C":     complete(f0);
                    default: begin
                        errors++;
                        $display("unknown command in test data: %s", line);
                    end
                endcase
            end
            $fclose(fd);
        end
        repeat (4) tick();
        if (exp_burst.size() != 0 || outstanding.size() != 0) begin
            errors++;
            $display("%0d bursts never issued, %0d never completed",
                     exp_burst.size(), outstanding.size());
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
